/* source/wb_soc_pkg.sv */
package wb_soc_pkg;

  // bus geometry
  localparam int BUS_ADR_W = 12;
  localparam int BUS_DAT_W = 32;

  // byte address, 4 kB window
  typedef logic [BUS_ADR_W-1:0] bus_addr_t;

  // one bus word
  typedef logic [BUS_DAT_W-1:0] bus_data_t;

  // master side of the bus
  // cyc and stb stay up until ack or err
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    bus_addr_t adr;
    bus_data_t dat;
  } wb_req_t;

  // slave side of the bus
  // ack or err is a one-cycle pulse, dat only valid with a read ack
  typedef struct packed {
    logic      ack;
    logic      err;
    bus_data_t dat;
  } wb_rsp_t;

  // power-on hold length after clk_reset drops, in clock cycles
  localparam int POR_CYCLES = 16;

endpackage

/* source/board_periph_pkg.sv */
package board_periph_pkg;

  // slot select bits in the byte address
  localparam int SLOT_LSB = 8;
  localparam int SLOT_W   = 2;
  typedef logic [SLOT_W-1:0] slot_t;

  // slot map, slot 3 left unmapped
  localparam slot_t SLOT_GPIO   = 2'd0;
  localparam slot_t SLOT_SWITCH = 2'd1;
  localparam slot_t SLOT_IRQ    = 2'd2;

  // word offset inside a slot
  localparam int REG_LSB = 2;
  localparam int REG_W   = 2;
  typedef logic [REG_W-1:0] reg_off_t;

  // per-peripheral register offsets
  localparam reg_off_t GPIO_REG_DATA  = 2'd0;
  localparam reg_off_t GPIO_REG_DIR   = 2'd1;
  localparam reg_off_t SW_REG_LEVEL   = 2'd0;
  localparam reg_off_t SW_REG_PENDING = 2'd1;
  localparam reg_off_t IRQ_REG_ENABLE = 2'd0;
  localparam reg_off_t IRQ_REG_STATUS = 2'd1;

  // peripheral widths
  localparam int GPIO_W       = 8;
  localparam int NUM_SWITCHES = 3;
  typedef logic [GPIO_W-1:0]       gpio_t;
  typedef logic [NUM_SWITCHES-1:0] sw_vec_t;

endpackage

/* source/por_reset_gen.sv */
`timescale 1ns/1ps

module por_reset_gen (
  input  logic i_clk,
  input  logic clk_reset,
  output logic periph_rst_o,
  output logic sys_ready_o
);

  // counter just wide enough for the hold length
  typedef logic [$clog2(wb_soc_pkg::POR_CYCLES + 1)-1:0] por_cnt_t;

  typedef enum logic {
    POR_HOLD,
    POR_RUN
  } por_state_t;

  por_state_t state_q;
  por_cnt_t   cnt_q;

  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      state_q <= POR_HOLD;
      cnt_q   <= por_cnt_t'(wb_soc_pkg::POR_CYCLES);
    end else begin
      case (state_q)
        POR_HOLD: begin
          // last hold cycle, leave reset on this edge
          if (cnt_q == por_cnt_t'(1)) begin
            state_q <= POR_RUN;
          end
          cnt_q <= cnt_q - 1'b1;
        end
        default: begin
          // stays here until the next clk_reset
          state_q <= POR_RUN;
        end
      endcase
    end
  end

  assign periph_rst_o = (state_q == POR_HOLD);
  assign sys_ready_o  = (state_q == POR_RUN);

endmodule

/* source/wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder (
  input  logic                i_clk,
  input  logic                clk_reset,
  input  logic                ready_i,
  input  wb_soc_pkg::wb_req_t host_req_i,
  output wb_soc_pkg::wb_rsp_t host_rsp_o,
  output wb_soc_pkg::wb_req_t gpio_req_o,
  output wb_soc_pkg::wb_req_t sw_req_o,
  output wb_soc_pkg::wb_req_t irq_req_o,
  input  wb_soc_pkg::wb_rsp_t gpio_rsp_i,
  input  wb_soc_pkg::wb_rsp_t sw_rsp_i,
  input  wb_soc_pkg::wb_rsp_t irq_rsp_i
);

  import wb_soc_pkg::*;
  import board_periph_pkg::*;

  slot_t slot;
  logic  host_act;
  logic  sel_gpio;
  logic  sel_sw;
  logic  sel_irq;
  logic  miss;
  logic  err_q;
  logic  err_hold_q;

  assign slot     = host_req_i.adr[SLOT_LSB +: SLOT_W];
  assign host_act = host_req_i.cyc & host_req_i.stb;

  // no slave gets selected while the peripherals sit in reset
  assign sel_gpio = ready_i & (slot == SLOT_GPIO);
  assign sel_sw   = ready_i & (slot == SLOT_SWITCH);
  assign sel_irq  = ready_i & (slot == SLOT_IRQ);

  // unmapped slot or not ready yet, decoder answers itself
  assign miss = host_act & ~(sel_gpio | sel_sw | sel_irq);

  // same request to all slaves, only stb is steered
  always_comb begin
    gpio_req_o     = host_req_i;
    gpio_req_o.stb = host_req_i.stb & sel_gpio;
    sw_req_o       = host_req_i;
    sw_req_o.stb   = host_req_i.stb & sel_sw;
    irq_req_o      = host_req_i;
    irq_req_o.stb  = host_req_i.stb & sel_irq;
  end

  // one err pulse per request
  // hold flag stays up until the master drops stb
  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      err_q      <= 1'b0;
      err_hold_q <= 1'b0;
    end else begin
      err_q      <= miss & ~err_hold_q;
      err_hold_q <= host_act & (err_hold_q | miss);
    end
  end

  // slaves drive zero when idle, so a plain OR merges them
  always_comb begin
    host_rsp_o.ack = gpio_rsp_i.ack | sw_rsp_i.ack | irq_rsp_i.ack;
    host_rsp_o.err = err_q | gpio_rsp_i.err | sw_rsp_i.err | irq_rsp_i.err;
    host_rsp_o.dat = gpio_rsp_i.dat | sw_rsp_i.dat | irq_rsp_i.dat;
  end

endmodule

/* source/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port (
  input  logic                      i_clk,
  input  logic                      clk_reset,
  input  wb_soc_pkg::wb_req_t       req_i,
  output wb_soc_pkg::wb_rsp_t       rsp_o,
  input  board_periph_pkg::gpio_t   gpio_i,
  output board_periph_pkg::gpio_t   gpio_o,
  output board_periph_pkg::gpio_t   gpio_oe_o
);

  import wb_soc_pkg::*;
  import board_periph_pkg::*;

  gpio_t     data_q;
  gpio_t     dir_q;
  gpio_t     in_meta_q;
  gpio_t     in_sync_q;
  reg_off_t  off;
  logic      access;
  logic      ack_q;
  bus_data_t rd_val;
  bus_data_t rd_q;

  assign off = req_i.adr[REG_LSB +: REG_W];

  // new request only, cycle after ack is the master still holding stb
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // driven pins read back the register, input pins the synced pad
  always_comb begin
    case (off)
      GPIO_REG_DATA: rd_val = bus_data_t'((data_q & dir_q) | (in_sync_q & ~dir_q));
      GPIO_REG_DIR:  rd_val = bus_data_t'(dir_q);
      default:       rd_val = '0;
    endcase
  end

  // two-flop input synchronizer
  always_ff @(posedge i_clk) begin
    in_meta_q <= gpio_i;
    in_sync_q <= in_meta_q;
  end

  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      data_q <= '0;
      dir_q  <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && req_i.we) begin
        // other offsets drop the write but still ack
        case (off)
          GPIO_REG_DATA: data_q <= req_i.dat[GPIO_W-1:0];
          GPIO_REG_DIR:  dir_q  <= req_i.dat[GPIO_W-1:0];
          default: begin
          end
        endcase
      end
    end
  end

  // read word, zero on writes and idle cycles
  always_ff @(posedge i_clk) begin
    rd_q <= (access && !req_i.we) ? rd_val : '0;
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
    rsp_o.dat = rd_q;
  end

  assign gpio_o    = data_q;
  assign gpio_oe_o = dir_q;

endmodule

/* source/switch_irq.sv */
`timescale 1ns/1ps

module switch_irq (
  input  logic                      i_clk,
  input  logic                      clk_reset,
  input  wb_soc_pkg::wb_req_t       req_i,
  output wb_soc_pkg::wb_rsp_t       rsp_o,
  input  board_periph_pkg::sw_vec_t switch_i,
  output board_periph_pkg::sw_vec_t pending_o
);

  import wb_soc_pkg::*;
  import board_periph_pkg::*;

  sw_vec_t   sw_meta_q;
  sw_vec_t   sw_sync_q;
  sw_vec_t   sw_prev_q;
  sw_vec_t   rise;
  sw_vec_t   clr;
  sw_vec_t   pending_q;
  reg_off_t  off;
  logic      access;
  logic      ack_q;
  bus_data_t rd_q;

  assign off    = req_i.adr[REG_LSB +: REG_W];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // low to high on the synced level
  assign rise = sw_sync_q & ~sw_prev_q;

  // write one to clear
  assign clr = (access && req_i.we && off == SW_REG_PENDING) ?
               req_i.dat[NUM_SWITCHES-1:0] : '0;

  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
      sw_prev_q <= '0;
      pending_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      // synchronizer then edge register
      sw_meta_q <= switch_i;
      sw_sync_q <= sw_meta_q;
      sw_prev_q <= sw_sync_q;
      // sticky, an edge in the clear cycle survives
      pending_q <= (pending_q & ~clr) | rise;
      ack_q     <= access;
    end
  end

  always_ff @(posedge i_clk) begin
    if (access && !req_i.we && off == SW_REG_LEVEL) begin
      rd_q <= bus_data_t'(sw_sync_q);
    end else if (access && !req_i.we && off == SW_REG_PENDING) begin
      rd_q <= bus_data_t'(pending_q);
    end else begin
      rd_q <= '0;
    end
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
    rsp_o.dat = rd_q;
  end

  assign pending_o = pending_q;

endmodule

/* source/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                      i_clk,
  input  logic                      clk_reset,
  input  wb_soc_pkg::wb_req_t       req_i,
  output wb_soc_pkg::wb_rsp_t       rsp_o,
  input  board_periph_pkg::sw_vec_t src_i,
  output logic                      irq_o
);

  import wb_soc_pkg::*;
  import board_periph_pkg::*;

  sw_vec_t   en_q;
  sw_vec_t   masked;
  reg_off_t  off;
  logic      access;
  logic      ack_q;
  logic      irq_q;
  bus_data_t rd_val;
  bus_data_t rd_q;

  assign off    = req_i.adr[REG_LSB +: REG_W];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // sources that are allowed through
  assign masked = src_i & en_q;

  always_comb begin
    case (off)
      IRQ_REG_ENABLE: rd_val = bus_data_t'(en_q);
      IRQ_REG_STATUS: rd_val = bus_data_t'(masked);
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (clk_reset) begin
      en_q  <= '0;
      irq_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      // status is read only
      if (access && req_i.we && off == IRQ_REG_ENABLE) begin
        en_q <= req_i.dat[NUM_SWITCHES-1:0];
      end
      // one line for the whole bank, lags the mask by a cycle
      irq_q <= |masked;
    end
  end

  always_ff @(posedge i_clk) begin
    rd_q <= (access && !req_i.we) ? rd_val : '0;
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
    rsp_o.dat = rd_q;
  end

  assign irq_o = irq_q;

endmodule

/* source/board_ctrl_top.sv */
`timescale 1ns/1ps

module board_ctrl_top (
  input  logic                      i_clk,
  input  logic                      clk_reset,
  input  wb_soc_pkg::wb_req_t       wb_req_i,
  output wb_soc_pkg::wb_rsp_t       wb_rsp_o,
  input  board_periph_pkg::gpio_t   gpio_i,
  output board_periph_pkg::gpio_t   gpio_o,
  output board_periph_pkg::gpio_t   gpio_oe_o,
  input  board_periph_pkg::sw_vec_t switch_i,
  output logic                      irq_o,
  output logic                      sys_ready_o
);

  import wb_soc_pkg::*;
  import board_periph_pkg::*;

  // peripheral reset, held past clk_reset by the POR counter
  logic    periph_rst;
  wb_req_t gpio_req;
  wb_req_t sw_req;
  wb_req_t irq_req;
  wb_rsp_t gpio_rsp;
  wb_rsp_t sw_rsp;
  wb_rsp_t irq_rsp;
  // switch pending bits feed the interrupt controller
  sw_vec_t sw_pending;

  por_reset_gen u_por (
    .i_clk        (i_clk),
    .clk_reset    (clk_reset),
    .periph_rst_o (periph_rst),
    .sys_ready_o  (sys_ready_o)
  );

  // decoder runs from the board reset so it can err during the hold
  wb_decoder u_dec (
    .i_clk      (i_clk),
    .clk_reset  (clk_reset),
    .ready_i    (sys_ready_o),
    .host_req_i (wb_req_i),
    .host_rsp_o (wb_rsp_o),
    .gpio_req_o (gpio_req),
    .sw_req_o   (sw_req),
    .irq_req_o  (irq_req),
    .gpio_rsp_i (gpio_rsp),
    .sw_rsp_i   (sw_rsp),
    .irq_rsp_i  (irq_rsp)
  );

  gpio_port u_gpio (
    .i_clk     (i_clk),
    .clk_reset (periph_rst),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  switch_irq u_sw (
    .i_clk     (i_clk),
    .clk_reset (periph_rst),
    .req_i     (sw_req),
    .rsp_o     (sw_rsp),
    .switch_i  (switch_i),
    .pending_o (sw_pending)
  );

  irq_ctrl u_irq (
    .i_clk     (i_clk),
    .clk_reset (periph_rst),
    .req_i     (irq_req),
    .rsp_o     (irq_rsp),
    .src_i     (sw_pending),
    .irq_o     (irq_o)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic clk_reset_o
);

  localparam int PERIOD_NS    = 20;
  localparam int RESET_CYCLES = 10;

  // free running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset high from time zero, dropped on a rising edge
  initial begin
    clk_reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    clk_reset_o <= 1'b0;
  end

endmodule

/* tb/board_ctrl_tb.sv */
`timescale 1ns/1ps

module board_ctrl_tb;

  import wb_soc_pkg::*;
  import board_periph_pkg::*;

  localparam int CLK_PERIOD_NS = 20;
  // rough cycle budget per test
  localparam int T1_CYCLES       = 80;
  localparam int T2_CYCLES       = 250;
  localparam int T3_CYCLES       = 50;
  localparam int T4_CYCLES       = 120;
  localparam int T5_CYCLES       = 250;
  localparam int MARGIN_CYCLES   = 200;
  localparam int WATCHDOG_CYCLES = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES +
                                   T5_CYCLES + MARGIN_CYCLES;
  localparam int RSP_TIMEOUT     = 4;
  localparam int GPIO_ROUNDS     = 8;
  localparam int MASK_ROUNDS     = 8;
  localparam slot_t SLOT_NONE    = 2'd3;

  logic    i_clk;
  logic    clk_reset;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  gpio_t   gpio_in;
  gpio_t   gpio_out;
  gpio_t   gpio_oe;
  sw_vec_t switches;
  logic    irq;
  logic    sys_ready;

  integer  seed;
  int      n_pass;
  int      n_err;
  int      test_err_base;

  // register model
  gpio_t   m_data;
  gpio_t   m_dir;
  gpio_t   m_gin;
  sw_vec_t m_level;
  sw_vec_t m_pending;
  sw_vec_t m_en;
  logic    m_ready;

  // expected responses in issue order
  wb_rsp_t exp_q[$];
  wb_rsp_t chk_exp;

  tb_clock_gen u_clk (
    .clk_o       (i_clk),
    .clk_reset_o (clk_reset)
  );

  board_ctrl_top i_dut (
    .i_clk       (i_clk),
    .clk_reset   (clk_reset),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .switch_i    (switches),
    .irq_o       (irq),
    .sys_ready_o (sys_ready)
  );

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
      n_err++;
    end else begin
      n_pass++;
    end
  endtask

  function automatic bus_addr_t reg_addr(input slot_t slot, input reg_off_t off);
    bus_addr_t adr;
    adr = '0;
    adr[SLOT_LSB +: SLOT_W] = slot;
    adr[REG_LSB +: REG_W]   = off;
    return adr;
  endfunction

  // expected bus answer from the register map rules
  function automatic wb_rsp_t expected_rsp(input logic we, input bus_addr_t adr);
    slot_t    slot;
    reg_off_t off;
    wb_rsp_t  rsp;
    gpio_t    mix;
    slot = adr[SLOT_LSB +: SLOT_W];
    off  = adr[REG_LSB +: REG_W];
    rsp  = '0;
    mix  = '0;
    if (!m_ready || slot == SLOT_NONE) begin
      // err carries zero data
      rsp.err = 1'b1;
    end else begin
      rsp.ack = 1'b1;
      if (!we) begin
        case (slot)
          SLOT_GPIO: begin
            if (off == GPIO_REG_DATA) begin
              // driven pins give the register bit and input pins the pad bit
              for (int pin = 0; pin < GPIO_W; pin++) begin
                mix[pin] = m_dir[pin] ? m_data[pin] : m_gin[pin];
              end
              rsp.dat = bus_data_t'(mix);
            end else if (off == GPIO_REG_DIR) begin
              rsp.dat = bus_data_t'(m_dir);
            end
          end
          SLOT_SWITCH: begin
            if (off == SW_REG_LEVEL) rsp.dat = bus_data_t'(m_level);
            else if (off == SW_REG_PENDING) rsp.dat = bus_data_t'(m_pending);
          end
          default: begin
            if (off == IRQ_REG_ENABLE) rsp.dat = bus_data_t'(m_en);
            else if (off == IRQ_REG_STATUS) rsp.dat = bus_data_t'(m_pending & m_en);
          end
        endcase
      end
    end
    return rsp;
  endfunction

  function automatic logic expected_irq();
    return |(m_pending & m_en);
  endfunction

  // register side effects of a write
  task automatic model_write(input bus_addr_t adr, input bus_data_t wdat);
    slot_t    slot;
    reg_off_t off;
    slot = adr[SLOT_LSB +: SLOT_W];
    off  = adr[REG_LSB +: REG_W];
    if (m_ready) begin
      case (slot)
        SLOT_GPIO: begin
          if (off == GPIO_REG_DATA) m_data = wdat[GPIO_W-1:0];
          else if (off == GPIO_REG_DIR) m_dir = wdat[GPIO_W-1:0];
        end
        // write one to clear
        SLOT_SWITCH: begin
          if (off == SW_REG_PENDING) m_pending = m_pending & ~wdat[NUM_SWITCHES-1:0];
        end
        SLOT_IRQ: begin
          if (off == IRQ_REG_ENABLE) m_en = wdat[NUM_SWITCHES-1:0];
        end
        default: begin
        end
      endcase
    end
  endtask

  // one request held until ack or err and dropped on the next edge
  task automatic bus_access(input logic we, input bus_addr_t adr, input bus_data_t wdat);
    int      waited;
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    waited  = 0;
    exp_q.push_back(expected_rsp(we, adr));
    @(posedge i_clk);
    wb_req <= req;
    @(negedge i_clk);
    while (!(wb_rsp.ack || wb_rsp.err) && waited < RSP_TIMEOUT) begin
      waited++;
      @(negedge i_clk);
    end
    if (!(wb_rsp.ack || wb_rsp.err)) begin
      $display("no ack or err within %0d cycles for address 0x%03h", RSP_TIMEOUT, adr);
      n_err++;
      exp_q.delete(exp_q.size() - 1);
    end
    if (we) model_write(adr, wdat);
    @(posedge i_clk);
    wb_req <= '0;
  endtask

  task automatic bus_read(input bus_addr_t adr);
    bus_access(1'b0, adr, '0);
  endtask

  task automatic bus_write(input bus_addr_t adr, input bus_data_t wdat);
    bus_access(1'b1, adr, wdat);
  endtask

  // pads change and settle through the synchronizer
  task automatic set_gpio_in(input gpio_t value);
    m_gin = value;
    @(posedge i_clk);
    gpio_in <= value;
    repeat (3) @(posedge i_clk);
  endtask

  // rising edges only become pending
  task automatic set_switches(input sw_vec_t value);
    m_pending = m_pending | (value & ~m_level);
    m_level   = value;
    @(posedge i_clk);
    switches <= value;
    repeat (10) @(posedge i_clk);
  endtask

  // direct outputs while the bus sits idle
  task automatic check_pins();
    @(negedge i_clk);
    check_equal("gpio_o", 64'(m_data), 64'(gpio_out));
    check_equal("gpio_oe_o", 64'(m_dir), 64'(gpio_oe));
    check_equal("irq_o", 64'(expected_irq()), 64'(irq));
    check_equal("sys_ready_o", 64'(m_ready), 64'(sys_ready));
    check_equal("wb_rsp_o", 64'(0), 64'(wb_rsp));
  endtask

  // edges from the fall of clk_reset until ready is seen
  task automatic count_ready_cycles();
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < 4 * POR_CYCLES) begin
      @(posedge i_clk);
      n++;
      @(negedge i_clk);
      done = sys_ready;
    end
    if (!done) begin
      $display("sys_ready_o did not rise within %0d cycles", n);
      n_err++;
    end else begin
      check_equal("sys_ready_o cycles", 64'(POR_CYCLES), 64'(n));
    end
  endtask

  task automatic end_test(input string name);
    if (n_err == test_err_base) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, n_err - test_err_base);
    test_err_base = n_err;
  endtask

  // every bus answer against the oldest expected one
  always @(negedge i_clk) begin
    if (wb_rsp.ack || wb_rsp.err) begin
      if (exp_q.size() == 0) begin
        $display("bus answered with no access outstanding at %0t", $time);
        n_err++;
      end else begin
        chk_exp = exp_q.pop_front();
        check_equal("wb_rsp_o", 64'(chk_exp), 64'(wb_rsp));
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    bus_data_t rnd_word;
    seed          = 32'h0eba7109;
    n_pass        = 0;
    n_err         = 0;
    test_err_base = 0;
    wb_req        = '0;
    gpio_in       = '0;
    switches      = '0;
    m_data        = '0;
    m_dir         = '0;
    m_gin         = '0;
    m_level       = '0;
    m_pending     = '0;
    m_en          = '0;
    m_ready       = 1'b0;

    // early read errs while the power-on count runs
    @(negedge clk_reset);
    fork
      count_ready_cycles();
      bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DIR));
    join
    m_ready = 1'b1;
    bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DIR));
    bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DATA));
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_PENDING));
    bus_read(reg_addr(SLOT_IRQ, IRQ_REG_STATUS));
    check_pins();
    end_test("1 power-on ready");

    // random direction, data and pad values
    for (int i = 0; i < GPIO_ROUNDS; i++) begin
      set_gpio_in(gpio_t'($random(seed)));
      rnd_word = $random(seed);
      bus_write(reg_addr(SLOT_GPIO, GPIO_REG_DIR), rnd_word);
      rnd_word = $random(seed);
      bus_write(reg_addr(SLOT_GPIO, GPIO_REG_DATA), rnd_word);
      check_pins();
      bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DATA));
      bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DIR));
    end
    end_test("2 gpio registers");

    // gpio state must survive an unmapped access
    rnd_word = $random(seed);
    bus_write(reg_addr(SLOT_NONE, GPIO_REG_DATA), rnd_word);
    bus_read(reg_addr(SLOT_NONE, GPIO_REG_DIR));
    bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DATA));
    bus_read(reg_addr(SLOT_GPIO, GPIO_REG_DIR));
    check_pins();
    end_test("3 unmapped slot");

    // rising edges and a selective clear while a falling edge sets nothing
    set_switches(3'b101);
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_LEVEL));
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_PENDING));
    bus_write(reg_addr(SLOT_SWITCH, SW_REG_PENDING), 32'h1);
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_PENDING));
    set_switches(3'b000);
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_LEVEL));
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_PENDING));
    set_switches(3'b010);
    bus_read(reg_addr(SLOT_SWITCH, SW_REG_PENDING));
    check_pins();
    end_test("4 switch pending");

    // random masks over the pending bits left by test 4
    for (int i = 0; i < MASK_ROUNDS; i++) begin
      rnd_word = $random(seed);
      bus_write(reg_addr(SLOT_IRQ, IRQ_REG_ENABLE), rnd_word);
      repeat (10) @(posedge i_clk);
      check_pins();
      bus_read(reg_addr(SLOT_IRQ, IRQ_REG_STATUS));
      bus_read(reg_addr(SLOT_IRQ, IRQ_REG_ENABLE));
    end
    // enable all and clear all pending so irq drops
    bus_write(reg_addr(SLOT_IRQ, IRQ_REG_ENABLE), 32'h7);
    bus_write(reg_addr(SLOT_SWITCH, SW_REG_PENDING), 32'h7);
    repeat (10) @(posedge i_clk);
    check_pins();
    bus_read(reg_addr(SLOT_IRQ, IRQ_REG_STATUS));
    end_test("5 interrupt mask");

    $display("checks passed: %0d, errors: %0d", n_pass, n_err);
    if (n_err == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* board_ctrl_top.f */
source/wb_soc_pkg.sv
source/board_periph_pkg.sv
source/por_reset_gen.sv
source/wb_decoder.sv
source/gpio_port.sv
source/switch_irq.sv
source/irq_ctrl.sv
source/board_ctrl_top.sv
tb/tb_clock_gen.sv
tb/board_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the board control testbench, verdict comes from the log
cd "$(dirname "$0")" || exit 1
mkdir -p build
verilator --binary --timing -Wno-fatal --top-module board_ctrl_tb -Mdir build \
  -f board_ctrl_top.f -o board_ctrl_sim > build/compile.log 2>&1 \
  && ./build/board_ctrl_sim > build/sim.log 2>&1 \
  || { echo "compile or run failed, see build/"; exit 1; }
grep -q "^Testbench passed$" build/sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL, see build/sim.log"; exit 1; }
